/* conv_window.f */
hdl/conv_window_pkg.sv
hdl/line_bank_ram.sv
hdl/bank_crossbar.sv
hdl/row_sequencer.sv
hdl/window_filter.sv
hdl/conv_window_top.sv
test/tb_conv_window.sv

/* Makefile */
# Verilator build and run for the 3x3 convolution window fetcher

VERILATOR ?= verilator
TOP       ?= tb_conv_window
FILELIST  ?= conv_window.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0 -Wno-fatal
PASS_MSG  ?= *** TEST PASSED ***

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The simulation reads its data file relative to the project root
run: $(BIN)
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

/* test/conv_window_input.txt */
# op bank addr data check sum0 sum1 sum2 sum3
# op 0 load, 1 filter; op to check in hex, sums in decimal
0 1 10 281E140A 0 0 0 0 0
0 1 11 50463C32 0 0 0 0 0
0 1 12 04030201 0 0 0 0 0
0 2 10 23190F05 0 0 0 0 0
0 2 11 4B41372D 0 0 0 0 0
0 2 12 08060402 0 0 0 0 0
0 3 10 82786E64 0 0 0 0 0
0 3 11 AAA0968C 0 0 0 0 0
0 3 12 0C090603 0 0 0 0 0
1 1 12 00000000 0 0 0 0 0
1 1 11 00000000 1 795 885 626 343
1 1 10 00000000 1 435 525 615 705
1 2 11 00000000 1 795 885 626 343
1 2 10 00000000 1 435 525 615 705
1 3 11 00000000 1 795 885 626 343
1 3 10 00000000 1 435 525 615 705
0 2 11 E6DCD2C8 0 0 0 0 0
1 1 11 00000000 1 1260 1350 936 498
1 1 10 00000000 1 435 525 770 1015

/* test/tb_conv_window.sv */
module tb_conv_window import conv_window_pkg::*; ();

    localparam int    CLK_PERIOD        = 10;
    localparam int    RESET_CYCLES      = 10;
    localparam int    CYCLES_PER_CMD    = 40;
    // Falling edges from raising req until ack is seen high
    localparam int    LOAD_ACK_CYCLES   = 3;
    localparam int    FILTER_ACK_CYCLES = 4;
    // Falling edges from dropping req until ack is seen low
    localparam int    RELEASE_CYCLES    = 2;
    localparam string INPUT_FILE        = "test/conv_window_input.txt";

    logic         clk = 1'b0;
    logic         reset;
    logic         req;
    conv_cmd_t    cmd;
    logic         ack;
    conv_result_t result;

    conv_cmd_t    cmd_q [$];
    bit           check_q [$];
    conv_result_t expect_q [$];

    int           error_count = 0;
    int           num_cmds = 0;
    int           cmds_done = 0;
    bit           cmds_loaded = 1'b0;

    conv_window_top DUT (
        .clk    (clk),
        .reset  (reset),
        .req    (req),
        .cmd    (cmd),
        .ack    (ack),
        .result (result)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    //////////////////////////////
    // Helpers

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("ERROR at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        end
    endtask

    // One command per line with hex fields then decimal sums
    task automatic read_commands();
        int           fd;
        int           n;
        int           op_v;
        int           bank_v;
        int           addr_v;
        int           check_v;
        int           s0;
        int           s1;
        int           s2;
        int           s3;
        logic [31:0]  data_v;
        string        line;
        conv_cmd_t    c;
        conv_result_t e;
        fd = $fopen(INPUT_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the command file %s", INPUT_FILE);
            error_count++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 0 && line.getc(0) != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %d %d %d %d", op_v, bank_v, addr_v,
                            data_v, check_v, s0, s1, s2, s3);
                if (n == 9) begin
                    c.op      = cmd_op_e'(op_v[0]);
                    c.bank    = bank_idx_e'(bank_v[1:0]);
                    c.addr    = addr_v[ADDR_BITS-1:0];
                    c.data    = data_v;
                    e.sum[0]  = s0[SUM_BITS-1:0];
                    e.sum[1]  = s1[SUM_BITS-1:0];
                    e.sum[2]  = s2[SUM_BITS-1:0];
                    e.sum[3]  = s3[SUM_BITS-1:0];
                    cmd_q.push_back(c);
                    check_q.push_back(check_v != 0);
                    expect_q.push_back(e);
                end else if (n > 0) begin
                    $display("Malformed line in the command file: %s", line);
                    error_count++;
                end
            end
        end
        $fclose(fd);
        num_cmds = cmd_q.size();
        if (num_cmds == 0) begin
            $display("The command file holds no commands");
            error_count++;
        end
    endtask

    // Four-phase req/ack with the result captured while ack is high
    task automatic handshake(input conv_cmd_t c, output conv_result_t res,
                             output int rise_cycles, output int fall_cycles);
        rise_cycles = 0;
        fall_cycles = 0;
        @(negedge clk);
        cmd = c;
        req = 1'b1;
        do begin
            @(negedge clk);
            rise_cycles++;
        end while (ack !== 1'b1);
        res = result;
        req = 1'b0;
        do begin
            @(negedge clk);
            fall_cycles++;
        end while (ack !== 1'b0);
    endtask

    task automatic run_command(input int idx);
        conv_result_t res;
        int           rise_cycles;
        int           fall_cycles;
        handshake(cmd_q[idx], res, rise_cycles, fall_cycles);
        if (cmd_q[idx].op == OP_LOAD) begin
            check_value("ack rise latency", 64'(LOAD_ACK_CYCLES), 64'(rise_cycles));
        end else begin
            check_value("ack rise latency", 64'(FILTER_ACK_CYCLES), 64'(rise_cycles));
        end
        check_value("ack fall latency", 64'(RELEASE_CYCLES), 64'(fall_cycles));
        // Priming passes read an unwritten slab
        if (check_q[idx]) begin
            for (int p = 0; p < PIXELS_PER_WORD; p++) begin
                check_value($sformatf("result.sum[%0d]", p), 64'(expect_q[idx].sum[p]),
                            64'(res.sum[p]));
            end
        end
        cmds_done++;
    endtask

    //////////////////////////////
    // Main sequence

    initial begin
        reset = 1'b1;
        req   = 1'b0;
        cmd   = '0;
        read_commands();
        cmds_loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        // Ack stays low before the first command
        @(negedge clk);
        check_value("ack", 64'(0), 64'(ack));
        for (int i = 0; i < num_cmds; i++) begin
            run_command(i);
        end
        $display("Summary: %0d errors, %0d of %0d commands run",
                 error_count, cmds_done, num_cmds);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Watchdog sized from the command count
    initial begin
        wait (cmds_loaded);
        #((RESET_CYCLES + CYCLES_PER_CMD * num_cmds) * CLK_PERIOD);
        $display("Watchdog expired: the req/ack handshake timed out after %0d of %0d commands",
                 cmds_done, num_cmds);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

/* hdl/conv_window_top.sv */
module conv_window_top import conv_window_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         req,
    input  conv_cmd_t    cmd,
    output logic         ack,
    output conv_result_t result
);

    row_port_t            row_ports [NUM_BANKS];
    logic                 fetch_en;
    logic                 filter_load;
    bank_wr_t             bank_wr [NUM_BANKS];

    logic [ADDR_BITS-1:0] buf_rd_addr [NUM_BANKS];
    logic [ADDR_BITS-1:0] slab_rd_addr [NUM_BANKS];
    logic [WORD_BITS-1:0] buf_rd_data [NUM_BANKS];
    logic [HALO_BITS-1:0] slab_rd_data [NUM_BANKS];
    logic [WORD_BITS-1:0] row_words [NUM_BANKS];
    logic [HALO_BITS-1:0] row_halos [NUM_BANKS];

    slab_wr_t             slab_wr [NUM_BANKS];
    // Slab write widened onto the common RAM write port
    bank_wr_t             slab_wr_port [NUM_BANKS];

    row_sequencer u_sequencer (
        .clk         (clk),
        .reset       (reset),
        .req         (req),
        .cmd         (cmd),
        .ack         (ack),
        .row_ports   (row_ports),
        .fetch_en    (fetch_en),
        .bank_wr     (bank_wr),
        .filter_load (filter_load)
    );

    bank_crossbar u_crossbar (
        .clk          (clk),
        .reset        (reset),
        .en           (fetch_en),
        .row_ports    (row_ports),
        .buf_rd_data  (buf_rd_data),
        .slab_rd_data (slab_rd_data),
        .buf_rd_addr  (buf_rd_addr),
        .slab_rd_addr (slab_rd_addr),
        .row_words    (row_words),
        .row_halos    (row_halos),
        .slab_wr      (slab_wr)
    );

    window_filter u_filter (
        .clk       (clk),
        .reset     (reset),
        .load      (filter_load),
        .row_words (row_words),
        .row_halos (row_halos),
        .result    (result)
    );

    //////////////////////////////
    // Line buffer and slab banks

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        assign slab_wr_port[b] = '{
            we:   slab_wr[b].we,
            addr: slab_wr[b].addr,
            data: WORD_BITS'(slab_wr[b].data)
        };

        line_bank_ram #(.WIDTH(WORD_BITS)) u_buf_ram (
            .clk     (clk),
            .wr      (bank_wr[b]),
            .rd_addr (buf_rd_addr[b]),
            .rd_data (buf_rd_data[b])
        );

        line_bank_ram #(.WIDTH(HALO_BITS)) u_slab_ram (
            .clk     (clk),
            .wr      (slab_wr_port[b]),
            .rd_addr (slab_rd_addr[b]),
            .rd_data (slab_rd_data[b])
        );
    end

endmodule

/* hdl/window_filter.sv */
module window_filter import conv_window_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 load,
    input  logic [WORD_BITS-1:0] row_words [NUM_BANKS],
    input  logic [HALO_BITS-1:0] row_halos [NUM_BANKS],
    output conv_result_t         result
);

    // Four word pixels then two halo pixels, pixel 0 in the low byte
    logic [WORD_BITS+HALO_BITS-1:0]           ext_rows [NUM_BANKS];
    logic [PIXELS_PER_WORD-1:0][SUM_BITS-1:0] box_sums;

    always_comb begin
        for (int r = 0; r < NUM_BANKS; r++) begin
            ext_rows[r] = {row_halos[r], row_words[r]};
        end
    end

    // Window p spans extended pixels p to p+2 on every row
    always_comb begin
        box_sums = '0;
        for (int p = 0; p < PIXELS_PER_WORD; p++) begin
            for (int r = 0; r < NUM_BANKS; r++) begin
                for (int k = 0; k < KERNEL_SIZE; k++) begin
                    box_sums[p] = box_sums[p]
                                + SUM_BITS'(ext_rows[r][(p + k) * PIXEL_BITS +: PIXEL_BITS]);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
        end else if (load) begin
            result.sum <= box_sums;
        end
    end

endmodule

/* hdl/row_sequencer.sv */
module row_sequencer import conv_window_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      req,
    input  conv_cmd_t cmd,
    output logic      ack,
    output row_port_t row_ports [NUM_BANKS],
    output logic      fetch_en,
    output bank_wr_t  bank_wr [NUM_BANKS],
    output logic      filter_load
);

    typedef enum logic [2:0] {
        IDLE,
        WRITE,
        FETCH,
        WAIT_DATA,
        FILTER,
        ACK,
        RELEASE
    } state_e;

    state_e               state;
    state_e               state_next;

    // Zero based top bank for the row rotation
    logic [1:0]           top_base;
    logic [ADDR_BITS-1:0] halo_addr;
    logic                 rows_active;

    //////////////////////////////
    // FSM

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        unique case (state)
            IDLE: begin
                if (req) begin
                    if (cmd.op == OP_LOAD) begin
                        state_next = WRITE;
                    end else begin
                        state_next = FETCH;
                    end
                end
            end
            WRITE:     state_next = ACK;
            FETCH:     state_next = WAIT_DATA;
            WAIT_DATA: state_next = FILTER;
            FILTER:    state_next = ACK;
            // Hold until the host drops req
            ACK: begin
                if (!req) begin
                    state_next = RELEASE;
                end
            end
            RELEASE:   state_next = IDLE;
            default:   state_next = IDLE;
        endcase
    end

    // Lags the state by one cycle, so ack rises after the result is in
    // and falls one cycle after req is seen low
    always_ff @(posedge clk) begin
        if (reset) begin
            ack <= 1'b0;
        end else begin
            ack <= (state == FILTER) || (state == ACK);
        end
    end

    //////////////////////////////
    // Datapath controls

    assign top_base    = (cmd.bank == BANK_NONE) ? 2'd0 : cmd.bank - 2'd1;
    assign halo_addr   = cmd.addr + 1'b1;
    assign rows_active = (state == FETCH) || (state == WAIT_DATA) || (state == FILTER);
    assign fetch_en    = (state == FETCH);
    assign filter_load = (state == FILTER);

    // Rows stay on their banks until the filter register has loaded
    always_comb begin
        for (int r = 0; r < NUM_BANKS; r++) begin
            row_ports[r].buf_idx   = BANK_NONE;
            row_ports[r].buf_addr  = ADDR_IDLE;
            row_ports[r].slab_idx  = BANK_NONE;
            row_ports[r].slab_addr = ADDR_IDLE;
            if (rows_active) begin
                row_ports[r].buf_idx   = bank_of((top_base + r) % NUM_BANKS);
                row_ports[r].buf_addr  = cmd.addr;
                row_ports[r].slab_idx  = bank_of((top_base + r) % NUM_BANKS);
                row_ports[r].slab_addr = halo_addr;
            end
        end
    end

    // Single cycle write into the named bank
    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            bank_wr[b].we   = (state == WRITE) && (cmd.bank == bank_of(b));
            bank_wr[b].addr = cmd.addr;
            bank_wr[b].data = cmd.data;
        end
    end

endmodule

/* hdl/bank_crossbar.sv */
module bank_crossbar import conv_window_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 en,
    input  row_port_t            row_ports [NUM_BANKS],
    input  logic [WORD_BITS-1:0] buf_rd_data [NUM_BANKS],
    input  logic [HALO_BITS-1:0] slab_rd_data [NUM_BANKS],
    output logic [ADDR_BITS-1:0] buf_rd_addr [NUM_BANKS],
    output logic [ADDR_BITS-1:0] slab_rd_addr [NUM_BANKS],
    output logic [WORD_BITS-1:0] row_words [NUM_BANKS],
    output logic [HALO_BITS-1:0] row_halos [NUM_BANKS],
    output slab_wr_t             slab_wr [NUM_BANKS]
);

    // Bank claimed by at least one row this cycle
    logic                 buf_sel [NUM_BANKS];

    // Indices of the last fetch, steer the data that comes back
    bank_idx_e            buf_idx_q [NUM_BANKS];
    bank_idx_e            slab_idx_q [NUM_BANKS];

    logic                 slab_we_q [NUM_BANKS];
    logic [ADDR_BITS-1:0] slab_addr_q [NUM_BANKS];

    //////////////////////////////
    // Address routing

    // Walk rows from last to first so row1 wins a shared bank
    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            buf_rd_addr[b]  = ADDR_IDLE;
            slab_rd_addr[b] = ADDR_IDLE;
            buf_sel[b]      = 1'b0;
            for (int r = NUM_BANKS - 1; r >= 0; r--) begin
                if (row_ports[r].buf_idx == bank_of(b)) begin
                    buf_rd_addr[b] = row_ports[r].buf_addr;
                    buf_sel[b]     = 1'b1;
                end
                if (row_ports[r].slab_idx == bank_of(b)) begin
                    slab_rd_addr[b] = row_ports[r].slab_addr;
                end
            end
        end
    end

    //////////////////////////////
    // Fetch state

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_BANKS; i++) begin
                buf_idx_q[i]   <= BANK_NONE;
                slab_idx_q[i]  <= BANK_NONE;
                slab_we_q[i]   <= 1'b0;
                slab_addr_q[i] <= ADDR_IDLE;
            end
        end else begin
            for (int i = 0; i < NUM_BANKS; i++) begin
                slab_we_q[i] <= en && buf_sel[i];
            end
            if (en) begin
                for (int i = 0; i < NUM_BANKS; i++) begin
                    buf_idx_q[i]   <= row_ports[i].buf_idx;
                    slab_idx_q[i]  <= row_ports[i].slab_idx;
                    slab_addr_q[i] <= buf_rd_addr[i];
                end
            end
        end
    end

    //////////////////////////////
    // Return path

    // Unclaimed rows read as zero
    always_comb begin
        for (int r = 0; r < NUM_BANKS; r++) begin
            row_words[r] = '0;
            row_halos[r] = '0;
            for (int b = 0; b < NUM_BANKS; b++) begin
                if (buf_idx_q[r] == bank_of(b)) begin
                    row_words[r] = buf_rd_data[b];
                end
                if (slab_idx_q[r] == bank_of(b)) begin
                    row_halos[r] = slab_rd_data[b];
                end
            end
        end
    end

    // Low two pixels go back to the slab of the same bank
    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            slab_wr[b].we   = slab_we_q[b];
            slab_wr[b].addr = slab_addr_q[b];
            slab_wr[b].data = buf_rd_data[b][HALO_BITS-1:0];
        end
    end

endmodule

/* hdl/line_bank_ram.sv */
module line_bank_ram import conv_window_pkg::*; #(
    parameter int WIDTH = WORD_BITS
) (
    input  logic                 clk,
    input  bank_wr_t             wr,
    input  logic [ADDR_BITS-1:0] rd_addr,
    output logic [WIDTH-1:0]     rd_data
);

    logic [WIDTH-1:0] mem [2**ADDR_BITS];

    // Read before write on a shared address
    always_ff @(posedge clk) begin
        if (wr.we) begin
            mem[wr.addr] <= wr.data[WIDTH-1:0];
        end
        rd_data <= mem[rd_addr];
    end

endmodule

/* hdl/conv_window_pkg.sv */
package conv_window_pkg;

    //////////////////////////////
    // Sizes

    localparam int PIXELS_PER_WORD = 4;
    localparam int PIXEL_BITS      = 8;
    localparam int WORD_BITS       = PIXELS_PER_WORD * PIXEL_BITS;
    // Two pixels per slab entry
    localparam int HALO_BITS       = 2 * PIXEL_BITS;
    localparam int ADDR_BITS       = 8;
    // Nine 8-bit pixels fit in 12 bits
    localparam int SUM_BITS        = 12;
    localparam int NUM_BANKS       = 3;
    localparam int KERNEL_SIZE     = 3;

    // All ones means no access
    localparam logic [ADDR_BITS-1:0] ADDR_IDLE = '1;

    //////////////////////////////
    // Types

    typedef enum logic [1:0] {
        BANK_NONE = 2'd0,
        BANK_1    = 2'd1,
        BANK_2    = 2'd2,
        BANK_3    = 2'd3
    } bank_idx_e;

    typedef enum logic {
        OP_LOAD   = 1'b0,
        OP_FILTER = 1'b1
    } cmd_op_e;

    // Host command, bank is the top row for a filter pass
    typedef struct packed {
        cmd_op_e                op;
        bank_idx_e              bank;
        logic [ADDR_BITS-1:0]   addr;
        logic [WORD_BITS-1:0]   data;
    } conv_cmd_t;

    typedef struct packed {
        bank_idx_e              buf_idx;
        logic [ADDR_BITS-1:0]   buf_addr;
        bank_idx_e              slab_idx;
        logic [ADDR_BITS-1:0]   slab_addr;
    } row_port_t;

    typedef struct packed {
        logic                   we;
        logic [ADDR_BITS-1:0]   addr;
        logic [WORD_BITS-1:0]   data;
    } bank_wr_t;

    typedef struct packed {
        logic                   we;
        logic [ADDR_BITS-1:0]   addr;
        logic [HALO_BITS-1:0]   data;
    } slab_wr_t;

    // sum[0] belongs to pixel position 0
    typedef struct packed {
        logic [PIXELS_PER_WORD-1:0][SUM_BITS-1:0] sum;
    } conv_result_t;

    // Array position 0..2 to bank selector
    function automatic bank_idx_e bank_of(input int unsigned bank);
        case (bank)
            0:       return BANK_1;
            1:       return BANK_2;
            default: return BANK_3;
        endcase
    endfunction

endpackage
